// File: logic/rack_pkg.sv
package rack_pkg;

    // datapath word, shared by rates, parameters, currents and counts
    localparam int data_w = 32;
    typedef logic [data_w-1:0] word_t;

    // host register map
    localparam int addr_w = 4;
    typedef enum logic [addr_w-1:0] {
        addr_ia_offset = 4'd0,
        addr_ii_offset = 4'd1,
        addr_ia_gain   = 4'd2,
        addr_ii_gain   = 4'd3,
        addr_divider   = 4'd4,
        addr_ia_count  = 4'd8,   // read only
        addr_ii_count  = 4'd9    // read only
    } reg_addr_t;

    // fixed-point formats
    localparam int gain_frac_bits = 8;  // Q.8 gain, 256 is unity
    localparam int current_shift  = 6;  // integer current to fixed point
    localparam int dither_bits    = 6;  // low current bits taken from the lfsr

    // neuron constants
    localparam word_t th_scaled  = 32'd30720;  // 30 mV scaled by 1024
    localparam int    leak_shift = 4;          // leak is v >> 4 per tick

    // tick ratios
    localparam int steps_per_ms = 16;                   // neuron ticks per sim tick
    localparam int step_w       = $clog2(steps_per_ms); // step counter width

    // reset defaults of the host registers
    localparam word_t def_offset  = 32'd10;   // 10.12 pps rounded
    localparam word_t def_gain    = 32'd256;  // unity
    localparam word_t def_divider = 32'd3;

    // dither generator, x^32 + x^22 + x^2 + x + 1 in galois form
    localparam word_t lfsr_taps    = 32'h8020_0003;
    localparam word_t lfsr_seed_ia = 32'h1d2c_3b4a;
    localparam word_t lfsr_seed_ii = 32'h5e6f_7081;  // must differ from the ia seed

endpackage

// File: logic/trig_param_if.sv
interface trig_param_if;
    import rack_pkg::*;

    // host-loaded parameters, all held in host_reg_map
    word_t ia_offset;  // pps removed from the ia rate
    word_t ii_offset;  // pps removed from the ii rate
    word_t ia_gain;    // Q.8
    word_t ii_gain;    // Q.8
    word_t divider;    // neuron tick every divider+1 cycles

    modport bank (
        output ia_offset, ii_offset, ia_gain, ii_gain, divider
    );

    // each afferent picks its own pair by parameter
    modport afferent (
        input ia_offset, ii_offset, ia_gain, ii_gain
    );

    modport ticks (
        input divider
    );

endinterface

// File: logic/host_reg_map.sv
module host_reg_map (
    input  logic                ep50trig,
    input  logic                reset_global,
    // host write, four-phase req/ack
    input  logic                i_wr_req,
    input  rack_pkg::reg_addr_t i_wr_addr,
    input  rack_pkg::word_t     i_wr_data,
    output logic                o_wr_ack,
    // host read, one cycle latency
    input  rack_pkg::reg_addr_t i_rd_addr,
    output rack_pkg::word_t     o_rd_data,
    // spike counts from the neurons
    input  rack_pkg::word_t     i_ia_count,
    input  rack_pkg::word_t     i_ii_count,
    trig_param_if.bank          params
);
    import rack_pkg::*;

    logic wr_fire;  // single load per handshake

    // load only on the first edge of a request, ack still low
    assign wr_fire = i_wr_req && !o_wr_ack;

    // ack handshake
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            o_wr_ack <= 1'b0;
        end else if (wr_fire) begin
            o_wr_ack <= 1'b1;     // rises with the load
        end else if (!i_wr_req) begin
            o_wr_ack <= 1'b0;     // host has let go
        end
    end

    // parameter bank
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            params.ia_offset <= def_offset;
            params.ii_offset <= def_offset;
            params.ia_gain   <= def_gain;
            params.ii_gain   <= def_gain;
            params.divider   <= def_divider;
        end else if (wr_fire) begin
            case (i_wr_addr)
                addr_ia_offset: params.ia_offset <= i_wr_data;
                addr_ii_offset: params.ii_offset <= i_wr_data;
                addr_ia_gain:   params.ia_gain   <= i_wr_data;
                addr_ii_gain:   params.ii_gain   <= i_wr_data;
                addr_divider:   params.divider   <= i_wr_data;
                default: begin
                    // counts and unmapped addresses, acked and dropped
                end
            endcase
        end
    end

    // registered read mux
    always_ff @(posedge ep50trig) begin
        case (i_rd_addr)
            addr_ia_offset: o_rd_data <= params.ia_offset;
            addr_ii_offset: o_rd_data <= params.ii_offset;
            addr_ia_gain:   o_rd_data <= params.ia_gain;
            addr_ii_gain:   o_rd_data <= params.ii_gain;
            addr_divider:   o_rd_data <= params.divider;
            addr_ia_count:  o_rd_data <= i_ia_count;
            addr_ii_count:  o_rd_data <= i_ii_count;
            default:        o_rd_data <= '0;   // unmapped reads zero
        endcase
    end

    // ack may only rise at an edge where the host was requesting
    a_ack_needs_req : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        $rose(o_wr_ack) |-> $past(i_wr_req)
    ) else $error("o_wr_ack rose without i_wr_req");

endmodule

// File: logic/tick_gen.sv
module tick_gen (
    input  logic        ep50trig,
    input  logic        reset_global,
    trig_param_if.ticks params,
    output logic        o_neuron_tick,  // one cycle every divider+1 cycles
    output logic        o_sim_tick      // one per simulated ms
);
    import rack_pkg::*;

    word_t             cyc_cnt;   // cycles into the current neuron period
    word_t             div_q;     // divider in use, refreshed at wrap
    logic [step_w-1:0] step_cnt;  // neuron ticks into the current ms

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            cyc_cnt       <= '0;
            div_q         <= def_divider;
            step_cnt      <= '0;
            o_neuron_tick <= 1'b0;
            o_sim_tick    <= 1'b0;
        end else if (cyc_cnt == div_q) begin
            cyc_cnt       <= '0;
            div_q         <= params.divider;  // new divider only lands here
            o_neuron_tick <= 1'b1;
            if (step_cnt == step_w'(steps_per_ms - 1)) begin
                step_cnt   <= '0;
                o_sim_tick <= 1'b1;           // last step of the ms
            end else begin
                step_cnt   <= step_cnt + 1'b1;
                o_sim_tick <= 1'b0;
            end
        end else begin
            cyc_cnt       <= cyc_cnt + 1'b1;
            o_neuron_tick <= 1'b0;
            o_sim_tick    <= 1'b0;
        end
    end

    // a sim tick is always one of the neuron ticks
    a_sim_on_neuron : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_sim_tick |-> o_neuron_tick
    ) else $error("o_sim_tick without o_neuron_tick");

endmodule

// File: logic/afferent_current.sv
module afferent_current #(
    parameter bit              is_ii = 1'b0,                // 0 takes the ia pair, 1 the ii pair
    parameter rack_pkg::word_t seed  = rack_pkg::lfsr_seed_ia
) (
    input  logic            ep50trig,
    input  logic            reset_global,
    input  logic            i_neuron_tick,
    input  rack_pkg::word_t i_rate,        // afferent rate in pps
    trig_param_if.afferent  params,
    output rack_pkg::word_t o_current      // fixed point, low bits dithered
);
    import rack_pkg::*;

    word_t                 offset;
    word_t                 gain;
    word_t                 rate_net;    // rate above offset
    logic [2*data_w-1:0]   prod;        // full-width rate x gain
    word_t                 rate_gained; // back to integer pps
    word_t                 cur_fixed;   // integer current moved to fixed point
    word_t                 lfsr_q;

    // fixed pick between the two pairs
    assign offset = is_ii ? params.ii_offset : params.ia_offset;
    assign gain   = is_ii ? params.ii_gain   : params.ia_gain;

    // clamp at zero below offset
    assign rate_net = (i_rate > offset) ? (i_rate - offset) : '0;

    assign prod        = rate_net * gain;
    assign rate_gained = word_t'(prod >> gain_frac_bits);  // drop Q.8 fraction
    assign cur_fixed   = rate_gained << current_shift;

    // galois lfsr, one step per neuron tick
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            lfsr_q <= seed;
        end else if (i_neuron_tick) begin
            lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? lfsr_taps : '0);
        end
    end

    // current lands the cycle after the tick
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            o_current <= '0;
        end else if (i_neuron_tick) begin
            o_current <= {cur_fixed[data_w-1:dither_bits], lfsr_q[dither_bits-1:0]};
        end
    end

endmodule

// File: logic/spiking_neuron.sv
module spiking_neuron (
    input  logic            ep50trig,
    input  logic            reset_global,
    input  logic            i_neuron_tick,
    input  rack_pkg::word_t i_current,     // fixed point input current
    output logic            o_spike,       // one cycle per firing
    output rack_pkg::word_t o_count        // cumulative spikes
);
    import rack_pkg::*;

    word_t         v_q;     // membrane potential
    word_t         v_leak;
    logic [data_w:0] v_sum; // one extra bit so a big current cannot wrap
    logic          fire;

    assign v_leak = v_q >> leak_shift;

    // v + I - v/16, the leak never exceeds v so no underflow
    assign v_sum = {1'b0, v_q - v_leak} + {1'b0, i_current};
    assign fire  = (v_sum >= {1'b0, th_scaled});

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            v_q     <= '0;
            o_spike <= 1'b0;
            o_count <= '0;
        end else if (i_neuron_tick) begin
            if (fire) begin
                v_q     <= '0;            // reset to rest after firing
                o_spike <= 1'b1;
                o_count <= o_count + 1'b1;
            end else begin
                v_q     <= v_sum[data_w-1:0];  // below threshold, fits in a word
                o_spike <= 1'b0;
            end
        end else begin
            o_spike <= 1'b0;  // spike lasts one cycle only
        end
    end

    // the count only moves up, a reset is the only way back to zero
    a_count_monotonic : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        !$past(reset_global) |-> (o_count >= $past(o_count))
    ) else $error("spike count went down without reset");

endmodule

// File: logic/rack_top.sv
module rack_top (
    input  logic                ep50trig,
    input  logic                reset_global,
    // afferent rates in pps
    input  rack_pkg::word_t     i_ia_rate,
    input  rack_pkg::word_t     i_ii_rate,
    // host write port
    input  logic                i_wr_req,
    input  rack_pkg::reg_addr_t i_wr_addr,
    input  rack_pkg::word_t     i_wr_data,
    output logic                o_wr_ack,
    // host read port
    input  rack_pkg::reg_addr_t i_rd_addr,
    output rack_pkg::word_t     o_rd_data,
    // spikes and the ms tick
    output logic                o_ia_spike,
    output logic                o_ii_spike,
    output logic                o_sim_tick
);
    import rack_pkg::*;

    logic  neuron_tick;
    word_t ia_current;
    word_t ii_current;
    word_t ia_count;
    word_t ii_count;

    trig_param_if params ();  // register bank to datapath

    host_reg_map u_reg_map (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_wr_req     (i_wr_req),
        .i_wr_addr    (i_wr_addr),
        .i_wr_data    (i_wr_data),
        .o_wr_ack     (o_wr_ack),
        .i_rd_addr    (i_rd_addr),
        .o_rd_data    (o_rd_data),
        .i_ia_count   (ia_count),
        .i_ii_count   (ii_count),
        .params       (params.bank)
    );

    tick_gen u_ticks (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .params        (params.ticks),
        .o_neuron_tick (neuron_tick),
        .o_sim_tick    (o_sim_tick)
    );

    // ia path
    afferent_current #(.is_ii(1'b0), .seed(lfsr_seed_ia)) u_ia_current (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_neuron_tick (neuron_tick),
        .i_rate        (i_ia_rate),
        .params        (params.afferent),
        .o_current     (ia_current)
    );

    spiking_neuron u_ia_neuron (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_neuron_tick (neuron_tick),
        .i_current     (ia_current),
        .o_spike       (o_ia_spike),
        .o_count       (ia_count)
    );

    // ii path, own seed so the dither is uncorrelated
    afferent_current #(.is_ii(1'b1), .seed(lfsr_seed_ii)) u_ii_current (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_neuron_tick (neuron_tick),
        .i_rate        (i_ii_rate),
        .params        (params.afferent),
        .o_current     (ii_current)
    );

    spiking_neuron u_ii_neuron (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_neuron_tick (neuron_tick),
        .i_current     (ii_current),
        .o_spike       (o_ii_spike),
        .o_count       (ii_count)
    );

endmodule

// File: verif/tb_clock.sv
module tb_clock #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 8
) (
    output logic ep50trig,
    output logic reset_global
);
    timeunit 1ns;
    timeprecision 100ps;

    // free running board clock
    initial begin
        ep50trig = 1'b0;
        forever #(period_ns / 2) ep50trig = ~ep50trig;
    end

    // reset held high for the first few edges
    initial begin
        reset_global = 1'b1;
        repeat (reset_cycles) @(posedge ep50trig);
        reset_global <= 1'b0;  // released on an edge like any other input
    end

endmodule

// File: verif/rack_tb.sv
module rack_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rack_pkg::*;

    localparam int clk_period_ns  = 40;
    localparam int reset_cycles   = 8;
    localparam int rand_seed      = 69150;
    localparam int ack_timeout    = 16;                    // edges allowed for an ack move
    localparam int sim_tick_limit = 2 * 8 * steps_per_ms;  // two ms at the slowest divider used
    localparam word_t test_divider = 32'd5;
    // 240 pps above offset gives 15360 per tick, so v crosses threshold every third tick
    localparam word_t spike_rate  = 32'd250;
    localparam int spike_gap      = 3 * (int'(def_divider) + 1);
    localparam int spike_window   = 240;
    localparam int settle_cycles  = 48;                    // lets the last current drain
    localparam int silence_cycles = 256;

    // rough length of each test in cycles, summed for the watchdog
    localparam int len_defaults  = 40;
    localparam int len_handshake = 160;
    localparam int len_ticks     = 480;
    localparam int len_silence   = 300;
    localparam int len_spikes    = 320;
    localparam int watchdog_cycles = reset_cycles + len_defaults + len_handshake
                                   + len_ticks + len_silence + len_spikes + 200;

    logic      ep50trig;
    logic      reset_global;
    word_t     i_ia_rate;
    word_t     i_ii_rate;
    logic      i_wr_req;
    reg_addr_t i_wr_addr;
    word_t     i_wr_data;
    logic      o_wr_ack;
    reg_addr_t i_rd_addr;
    word_t     o_rd_data;
    logic      o_ia_spike;
    logic      o_ii_spike;
    logic      o_sim_tick;

    string current_test;
    int    error_count;
    int    errors_at_start;
    int    check_count;
    int    test_count;

    tb_clock #(.period_ns(clk_period_ns), .reset_cycles(reset_cycles)) u_clock (
        .ep50trig     (ep50trig),
        .reset_global (reset_global)
    );

    rack_top UUT (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_ia_rate    (i_ia_rate),
        .i_ii_rate    (i_ii_rate),
        .i_wr_req     (i_wr_req),
        .i_wr_addr    (i_wr_addr),
        .i_wr_data    (i_wr_data),
        .o_wr_ack     (o_wr_ack),
        .i_rd_addr    (i_rd_addr),
        .o_rd_data    (o_rd_data),
        .o_ia_spike   (o_ia_spike),
        .o_ii_spike   (o_ii_spike),
        .o_sim_tick   (o_sim_tick)
    );

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("error: %s (%s) expected %0d actual %0d",
                     current_test, what, expected, actual);
        end
    endtask

    // parameter registers in address order with their reset values
    function automatic reg_addr_t param_addr(input int idx);
        case (idx)
            0:       return addr_ia_offset;
            1:       return addr_ii_offset;
            2:       return addr_ia_gain;
            3:       return addr_ii_gain;
            default: return addr_divider;
        endcase
    endfunction

    function automatic word_t param_default(input int idx);
        case (idx)
            0, 1:    return 32'd10;   // offsets
            2, 3:    return 32'd256;  // unity gains
            default: return 32'd3;    // divider
        endcase
    endfunction

    task automatic begin_test(input string name);
        current_test    = name;
        errors_at_start = error_count;
        test_count++;
    endtask

    task automatic end_test;
        if (error_count == errors_at_start) begin
            $display("test %s: ok", current_test);
        end else begin
            $display("test %s: %0d errors", current_test, error_count - errors_at_start);
        end
    endtask

    // counts edges until ack reaches the level, sampled mid cycle
    task automatic wait_ack(input logic level, input string what, output int cycles);
        cycles = 0;
        do begin
            @(posedge ep50trig);
            @(negedge ep50trig);
            cycles++;
        end while (o_wr_ack !== level && cycles < ack_timeout);
        if (o_wr_ack !== level) begin
            error_count++;
            $display("test %s: ack did not go to %0b within %0d cycles during %s",
                     current_test, level, cycles, what);
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        int rise_cycles;
        int fall_cycles;
        @(posedge ep50trig);
        i_wr_req  <= 1'b1;
        i_wr_addr <= addr;
        i_wr_data <= data;
        wait_ack(1'b1, "write request", rise_cycles);
        check_value("ack rise edges", 32'd1, word_t'(rise_cycles));  // first edge with req
        @(posedge ep50trig);
        i_wr_req <= 1'b0;
        @(negedge ep50trig);
        check_value("ack held", 32'd1, word_t'(o_wr_ack));  // dut has not seen req low yet
        wait_ack(1'b0, "write release", fall_cycles);
        check_value("ack fall edges", 32'd1, word_t'(fall_cycles));
    endtask

    task automatic read_reg(input reg_addr_t addr, output word_t data);
        @(posedge ep50trig);
        i_rd_addr <= addr;
        @(posedge ep50trig);  // address sampled here
        @(negedge ep50trig);
        data = o_rd_data;
    endtask

    task automatic wait_sim_tick(output int cycles);
        cycles = 0;
        do begin
            @(negedge ep50trig);
            cycles++;
        end while (!o_sim_tick && cycles < sim_tick_limit);
        if (!o_sim_tick) begin
            error_count++;
            $display("test %s: no sim tick within %0d cycles", current_test, cycles);
        end
    endtask

    task automatic test_reset_defaults;
        word_t data;
        begin_test("reset_defaults");
        for (int i = 0; i < 5; i++) begin
            read_reg(param_addr(i), data);
            check_value(param_addr(i).name(), param_default(i), data);
        end
        read_reg(addr_ia_count, data);
        check_value("ia count", 32'd0, data);
        read_reg(addr_ii_count, data);
        check_value("ii count", 32'd0, data);
        end_test();
    endtask

    task automatic test_write_handshake;
        word_t written [5];
        word_t data;
        begin_test("write_handshake");
        for (int i = 0; i < 5; i++) begin
            // divider kept small so the tick period stays short
            written[i] = (i == 4) ? word_t'($urandom_range(7, 1)) : word_t'($urandom);
            write_reg(param_addr(i), written[i]);
            read_reg(param_addr(i), data);
            check_value(param_addr(i).name(), written[i], data);
        end
        write_reg(addr_ia_count, word_t'($urandom));  // acked, must be dropped
        write_reg(addr_ii_count, word_t'($urandom));
        read_reg(addr_ia_count, data);
        check_value("ia count after write", 32'd0, data);
        read_reg(addr_ii_count, data);
        check_value("ii count after write", 32'd0, data);
        for (int i = 0; i < 5; i++) begin  // no write disturbed a neighbour
            read_reg(param_addr(i), data);
            check_value("recheck", written[i], data);
        end
        for (int i = 0; i < 5; i++) begin
            write_reg(param_addr(i), param_default(i));
        end
        end_test();
    endtask

    task automatic test_tick_period;
        int gap;
        begin_test("tick_period");
        write_reg(addr_divider, test_divider);
        wait_sim_tick(gap);  // first ms may still mix old and new periods
        repeat (2) begin
            wait_sim_tick(gap);
            check_value("sim tick gap", (test_divider + 1) * steps_per_ms, word_t'(gap));
        end
        write_reg(addr_divider, param_default(4));
        end_test();
    endtask

    task automatic test_silence;
        int    ia_seen;
        int    ii_seen;
        word_t high_bits;
        word_t data;
        begin_test("silence_below_offset");
        ia_seen   = 0;
        ii_seen   = 0;
        high_bits = '0;
        @(posedge ep50trig);
        i_ia_rate <= param_default(0);          // right at the offset
        i_ii_rate <= param_default(1) - 32'd3;  // below it
        repeat (silence_cycles) begin
            @(negedge ep50trig);
            ia_seen   += int'(o_ia_spike);
            ii_seen   += int'(o_ii_spike);
            high_bits |= (UUT.ia_current | UUT.ii_current) >> dither_bits;  // dither only
        end
        check_value("current above dither", 32'd0, high_bits);
        check_value("ia spikes", 32'd0, word_t'(ia_seen));
        check_value("ii spikes", 32'd0, word_t'(ii_seen));
        read_reg(addr_ia_count, data);
        check_value("ia count", 32'd0, data);
        read_reg(addr_ii_count, data);
        check_value("ii count", 32'd0, data);
        end_test();
    endtask

    task automatic test_spike_counting;
        int    ia_seen;
        int    ii_seen;
        int    last_spike;
        word_t data;
        begin_test("spike_counting");
        ia_seen    = 0;
        ii_seen    = 0;
        last_spike = -1;
        @(posedge ep50trig);
        i_ia_rate <= spike_rate;
        i_ii_rate <= '0;
        for (int cyc = 0; cyc < spike_window + settle_cycles; cyc++) begin
            @(posedge ep50trig);
            if (cyc == spike_window) i_ia_rate <= '0;
            @(negedge ep50trig);
            if (o_ia_spike) begin
                ia_seen++;
                if (last_spike >= 0) begin  // after the first spike v restarts from zero
                    check_value("spike gap", word_t'(spike_gap), word_t'(cyc - last_spike));
                end
                last_spike = cyc;
            end
            ii_seen += int'(o_ii_spike);
        end
        if (ia_seen == 0) begin
            error_count++;
            $display("test %s: no spikes seen on o_ia_spike", current_test);
        end
        read_reg(addr_ia_count, data);
        check_value("ia count", word_t'(ia_seen), data);
        read_reg(addr_ii_count, data);
        check_value("ii count", 32'd0, data);
        check_value("ii spikes", 32'd0, word_t'(ii_seen));
        end_test();
    endtask

    initial begin
        i_ia_rate <= '0;
        i_ii_rate <= '0;
        i_wr_req  <= 1'b0;
        i_wr_addr <= addr_ia_offset;
        i_wr_data <= '0;
        i_rd_addr <= addr_ia_offset;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        void'($urandom(rand_seed));
        wait (reset_global == 1'b0);
        @(posedge ep50trig);
        test_reset_defaults();
        test_write_handshake();
        test_tick_period();
        test_silence();
        test_spike_counting();
        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog sized from the test lengths above
    initial begin
        #(watchdog_cycles * clk_period_ns);
        $display("watchdog: run still going after %0d cycles, stopping", watchdog_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

// File: list.f
logic/rack_pkg.sv
logic/trig_param_if.sv
logic/host_reg_map.sv
logic/tick_gen.sv
logic/afferent_current.sv
logic/spiking_neuron.sv
logic/rack_top.sv
verif/tb_clock.sv
verif/rack_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rack testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f list.f \
    --top-module rack_tb \
    -o rack_sim

./obj_dir/rack_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
